//--- osd_controller.f
+incdir+tb
src/osd_pkg.sv
src/osd_spi_slave.sv
src/osd_cmd_regs.sv
src/osd_raster.sv
src/osd_overlay.sv
src/osd_controller.sv
tb/osd_tb.sv

//--- Makefile
# Verilator build and run for the osd controller testbench

VERILATOR  ?= verilator
TOP        ?= osd_tb
FILELIST   ?= osd_controller.f
OBJ_DIR    ?= obj_dir
BUILD_ARGS ?= --binary --timing --assert -j 0
LINT_ARGS  ?= --lint-only --timing
PASS_TEXT  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_ARGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_ARGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/osd_tb_tasks.svh
// spi transfer and directed tests for osd_tb; tasks expect to start 1 ns after a rising clk edge
`ifndef osd_tb_tasks_svh
`define osd_tb_tasks_svh

// ----------------------------------------
// spi host side
// ----------------------------------------
// mode 0, msb first, 4 clk per sck half-period; sends tx_q, collects sdo into rx_q
task automatic spi_xfer();
  logic [7:0] tx;
  logic [7:0] rx_byte;
  rx_q.delete();
  scs_n = 1'b0;
  tick(4);
  foreach (tx_q[i]) begin
    tx      = tx_q[i];
    rx_byte = 8'h00;
    repeat (8) begin
      sdi = tx[7];
      tx  = tx << 1;
      tick(4);
      // key code bit is up before the rising edge
      rx_byte = {rx_byte[6:0], sdo};
      sck     = 1'b1;
      tick(4);
      sck = 1'b0;
    end
    rx_q.push_back(rx_byte);
  end
  tick(4);
  scs_n = 1'b1;
  tick(4);
endtask

// command byte plus one data byte, then settle
task automatic write_cmd(input logic [5:0] code, input logic [7:0] value);
  tx_q.delete();
  tx_q.push_back({code, 2'b00});
  tx_q.push_back(value);
  spi_xfer();
  tick(10);
endtask

task automatic check_eq(input string what, input logic [39:0] got, input logic [39:0] exp);
  assert (got === exp) else
    report_error($sformatf("%s is %0h, expected %0h", what, got, exp));
endtask

// all register outputs packed for whole-state compares
function automatic logic [32:0] reg_snapshot();
  return {osd_enable, key_disable, usrrst, cpurst, cpuhlt, chipset_config, cpu_config,
          memory_config, dither, hr_filter, lr_filter, scanline, floppy_config};
endfunction

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic reset_defaults();
  check_eq("osd_blank", 40'(osd_blank), 40'h0);
  check_eq("osd_pixel", 40'(osd_pixel), 40'h0);
  // cpurst, cpuhlt high; memory 0_00_01_01; rest zero
  check_eq("register state after reset", 40'(reg_snapshot()),
           40'({5'b00011, 5'h00, 4'h0, 7'h05, 8'h00, 4'h0}));
endtask

task automatic register_writes();
  logic [7:0] v_osd;
  logic [7:0] v_video;
  logic [7:0] v_cpu;
  logic [7:0] v_floppy;
  logic [7:0] junk;
  rand_byte(v_osd);
  write_cmd(cmd_osd_ctrl, v_osd);
  check_eq("key_disable", 40'(key_disable), 40'(v_osd[1]));
  check_eq("osd_enable", 40'(osd_enable), 40'(v_osd[0]));
  rand_byte(v_video);
  write_cmd(cmd_video_cfg, v_video);
  check_eq("dither", 40'(dither), 40'(v_video[7:6]));
  check_eq("hr_filter", 40'(hr_filter), 40'(v_video[5:4]));
  check_eq("lr_filter", 40'(lr_filter), 40'(v_video[3:2]));
  check_eq("scanline", 40'(scanline), 40'(v_video[1:0]));
  rand_byte(v_cpu);
  write_cmd(cmd_cpu_cfg, v_cpu);
  check_eq("cpu_config", 40'(cpu_config), 40'(v_cpu[3:0]));
  rand_byte(v_floppy);
  write_cmd(cmd_floppy_cfg, v_floppy);
  check_eq("floppy_config", 40'(floppy_config), 40'(v_floppy[3:0]));
  // no register answers to code 3f
  rand_byte(junk);
  write_cmd(6'b1_111_11, junk);
  check_eq("register state after unused command", 40'(reg_snapshot()),
           40'({v_osd[0], v_osd[1], 3'b011, 5'h00, v_cpu[3:0], 7'h05, v_video,
                v_floppy[3:0]}));
endtask

task automatic staged_config();
  logic [7:0] mem_v;
  logic [7:0] chip_v;
  write_cmd(cmd_reset_ctrl, 8'h00);
  check_eq("cpurst released", 40'(cpurst), 40'h0);
  rand_byte(mem_v);
  rand_byte(chip_v);
  write_cmd(cmd_memory_cfg, mem_v);
  write_cmd(cmd_chip_cfg, chip_v);
  // outputs hold their reset values while the cpu runs
  check_eq("memory_config while running", 40'(memory_config), 40'h05);
  check_eq("chipset_config while running", 40'(chipset_config), 40'h00);
  // cpu held in reset with usrrst set and cpuhlt clear
  write_cmd(cmd_reset_ctrl, 8'h03);
  check_eq("cpurst held", 40'(cpurst), 40'h1);
  check_eq("cpuhlt", 40'(cpuhlt), 40'h0);
  check_eq("usrrst", 40'(usrrst), 40'h1);
  check_eq("memory_config applied", 40'(memory_config), 40'(mem_v[6:0]));
  check_eq("chipset_config applied", 40'(chipset_config), 40'(chip_v[4:0]));
endtask

task automatic key_readback();
  logic [7:0] key;
  logic [7:0] b;
  rand_byte(key);
  osd_ctrl = key;
  tx_q.delete();
  // unused code so nothing gets written
  tx_q.push_back({6'b1_111_10, 2'b00});
  repeat (3) begin
    rand_byte(b);
    tx_q.push_back(b);
  end
  spi_xfer();
  foreach (rx_q[i]) begin
    check_eq($sformatf("sdo byte %0d", i), 40'(rx_q[i]), 40'(key));
  end
endtask

// sof on the first line, sol every line_clks; checks blank and pixel every cycle
task automatic run_frame(input logic enabled);
  int         v;
  int         c;
  logic       win_line;
  logic       exp_blank;
  logic       exp_pix;
  logic [2:0] r_idx;
  logic [2:0] ln_idx;
  for (int j = 0; j < frame_lines; j++) begin
    sol = 1'b1;
    sof = (j == 0);
    // one osd line per two video lines
    v        = j / 2;
    win_line = enabled && v >= v_start && v < v_start + 64;
    r_idx    = 3'((v - v_start) / 8);
    ln_idx   = 3'((v - v_start) % 8);
    for (int m = 1; m < line_clks; m++) begin
      tick(1);
      sol = 1'b0;
      sof = 1'b0;
      // registered output lags the window by one cycle past the counter
      c         = m - h_start - 2;
      exp_blank = win_line && c >= 0 && c < 256;
      exp_pix   = exp_blank && ref_buf[r_idx][8'(c)][ln_idx];
      assert (osd_blank === exp_blank) else
        report_error($sformatf("osd_blank is %b on line %0d offset %0d", osd_blank, j, m));
      if (!exp_blank || r_idx == 3'd0 || r_idx == 3'd7) begin
        assert (osd_pixel === exp_pix) else
          report_error($sformatf("osd_pixel is %b on line %0d offset %0d", osd_pixel, j, m));
      end
    end
    tick(1);
  end
endtask

task automatic buffer_overlay();
  logic [7:0] b;
  logic [2:0] row;
  write_cmd(cmd_osd_ctrl, 8'h01);
  check_eq("osd_enable", 40'(osd_enable), 40'h1);
  for (int k = 0; k < 2; k++) begin
    row = (k == 0) ? 3'd0 : 3'd7;
    tx_q.delete();
    tx_q.push_back({cmd_osd_buffer, 2'b00});
    tx_q.push_back({5'b00000, row});
    for (int c = 0; c < 256; c++) begin
      rand_byte(b);
      ref_buf[row][c[7:0]] = b;
      tx_q.push_back(b);
    end
    spi_xfer();
  end
  tick(4);
  run_frame(1'b1);
endtask

task automatic overlay_disable();
  write_cmd(cmd_osd_ctrl, 8'h00);
  check_eq("osd_enable", 40'(osd_enable), 40'h0);
  run_frame(1'b0);
endtask

`endif

//--- tb/osd_tb.sv
// directed testbench for osd_controller with the window at h_start 64 and v_start 4
`timescale 1ns/1ps
`default_nettype none

module osd_tb
  import osd_pkg::*;
();

  localparam int h_start     = 64;
  localparam int v_start     = 4;
  // enough video lines per frame to reach osd line 67 at video line 135
  localparam int frame_lines = 140;
  localparam int line_clks   = 400;
  // 8 bits of 2 half-periods of 4 clk each
  localparam int byte_clks   = 64;
  // two frames plus about 600 spi bytes and some slack
  localparam int watchdog_clks = 2 * frame_lines * line_clks + 600 * byte_clks + 20000;

  logic       clk;
  logic       reset;
  logic       scs_n;
  logic       sck;
  logic       sdi;
  logic       sdo;
  logic [7:0] osd_ctrl;
  logic       sol;
  logic       sof;
  logic       osd_blank;
  logic       osd_pixel;
  logic       osd_enable;
  logic       key_disable;
  logic       usrrst;
  logic       cpurst;
  logic       cpuhlt;
  logic [4:0] chipset_config;
  logic [3:0] cpu_config;
  logic [6:0] memory_config;
  logic [1:0] scanline;
  logic [1:0] lr_filter;
  logic [1:0] hr_filter;
  logic [1:0] dither;
  logic [3:0] floppy_config;

  // spi byte queues that spi_xfer sends and fills
  logic [7:0]  tx_q[$];
  logic [7:0]  rx_q[$];
  // expected buffer contents for rows 0 and 7
  logic [7:0]  ref_buf [8][256];
  logic [31:0] lfsr;

  osd_controller #(
    .h_start (h_start),
    .v_start (v_start)
  ) i_osd_controller (.*);

  // ----------------------------------------
  // clock, random source, error exit
  // ----------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // wait n rising edges, then step past them so drives land 1 ns late
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] val);
    val = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  `include "osd_tb_tasks.svh"

  // ----------------------------------------
  // watchdog and test sequence
  // ----------------------------------------
  initial begin
    repeat (watchdog_clks) @(posedge clk);
    $display("timeout: tests did not finish within %0d clock cycles", watchdog_clks);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset    = 1'b1;
    scs_n    = 1'b1;
    sck      = 1'b0;
    sdi      = 1'b0;
    osd_ctrl = 8'h00;
    sol      = 1'b0;
    sof      = 1'b0;
    lfsr     = 32'h786f317b;
    tick(10);
    reset = 1'b0;
    tick(2);
    reset_defaults();
    register_writes();
    staged_config();
    key_readback();
    buffer_overlay();
    overlay_disable();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/osd_controller.sv
// osd controller top; all logic runs on clk, no back-pressure toward the spi host
`timescale 1ns/1ps
`default_nettype none

module osd_controller
  import osd_pkg::*;
#(
  parameter int h_start = h_start_default,
  parameter int v_start = v_start_default
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       scs_n,
  input  logic       sck,
  input  logic       sdi,
  output logic       sdo,
  input  logic [7:0] osd_ctrl,
  input  logic       sol,
  input  logic       sof,
  output logic       osd_blank,
  output logic       osd_pixel,
  output logic       osd_enable,
  output logic       key_disable,
  output logic       usrrst,
  output logic       cpurst,
  output logic       cpuhlt,
  output logic [4:0] chipset_config,
  output logic [3:0] cpu_config,
  output logic [6:0] memory_config,
  output logic [1:0] scanline,
  output logic [1:0] lr_filter,
  output logic [1:0] hr_filter,
  output logic [1:0] dither,
  output logic [3:0] floppy_config
);

  // spi to decoder
  logic       rx;
  logic       cmd;
  logic [7:0] data;
  // decoder to buffer
  logic       buf_we;
  buf_addr_t  buf_addr;
  logic [7:0] buf_data;
  // raster to overlay
  logic       in_window;
  logic [7:0] col;
  logic [2:0] row;
  logic [2:0] line;

  osd_spi_slave i_spi (
    .clk      (clk),
    .reset    (reset),
    .scs_n    (scs_n),
    .sck      (sck),
    .sdi      (sdi),
    .osd_ctrl (osd_ctrl),
    .sdo      (sdo),
    .rx       (rx),
    .cmd      (cmd),
    .data     (data)
  );

  osd_cmd_regs i_regs (
    .clk            (clk),
    .reset          (reset),
    .rx             (rx),
    .cmd            (cmd),
    .data           (data),
    .osd_enable     (osd_enable),
    .key_disable    (key_disable),
    .usrrst         (usrrst),
    .cpurst         (cpurst),
    .cpuhlt         (cpuhlt),
    .chipset_config (chipset_config),
    .cpu_config     (cpu_config),
    .memory_config  (memory_config),
    .scanline       (scanline),
    .lr_filter      (lr_filter),
    .hr_filter      (hr_filter),
    .dither         (dither),
    .floppy_config  (floppy_config),
    .buf_we         (buf_we),
    .buf_addr       (buf_addr),
    .buf_data       (buf_data)
  );

  osd_raster #(
    .h_start (h_start),
    .v_start (v_start)
  ) i_raster (
    .clk       (clk),
    .reset     (reset),
    .sol       (sol),
    .sof       (sof),
    .in_window (in_window),
    .col       (col),
    .row       (row),
    .line      (line)
  );

  osd_overlay i_overlay (
    .clk        (clk),
    .reset      (reset),
    .sof        (sof),
    .osd_enable (osd_enable),
    .buf_we     (buf_we),
    .buf_addr   (buf_addr),
    .buf_data   (buf_data),
    .in_window  (in_window),
    .col        (col),
    .row        (row),
    .line       (line),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

`default_nettype wire

//--- src/osd_overlay.sv
// character buffer and pixel output; osd_enable only takes effect at the next sof
`timescale 1ns/1ps
`default_nettype none

module osd_overlay
  import osd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       sof,
  input  logic       osd_enable,
  input  logic       buf_we,
  input  buf_addr_t  buf_addr,
  input  logic [7:0] buf_data,
  input  logic       in_window,
  input  logic [7:0] col,
  input  logic [2:0] row,
  input  logic [2:0] line,
  output logic       osd_blank,
  output logic       osd_pixel
);

  logic [7:0] char_buf [osd_rows * osd_cols];
  logic [7:0] rd_data;
  logic [2:0] line_q;
  logic       frame_en;

  // ----------------------------------------
  // dual port buffer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (buf_we) begin
      char_buf[buf_addr] <= buf_data;
    end
  end

  // read side, line delayed with the data
  always_ff @(posedge clk) begin
    rd_data <= char_buf[{row, col}];
    line_q  <= line;
  end

  // ----------------------------------------
  // blank and pixel
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_en  <= 1'b0;
      osd_blank <= 1'b0;
    end else begin
      if (sof) begin
        frame_en <= osd_enable;
      end
      osd_blank <= in_window & frame_en;
    end
  end

  assign osd_pixel = rd_data[line_q] & osd_blank;

endmodule

`default_nettype wire

//--- src/osd_raster.sv
// beam counters; h_start+256 must stay below 2047 clk and a frame below 1023 osd lines
`timescale 1ns/1ps
`default_nettype none

module osd_raster
  import osd_pkg::*;
#(
  parameter int h_start = h_start_default,
  parameter int v_start = v_start_default
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       sol,
  input  logic       sof,
  output logic       in_window,
  output logic [7:0] col,
  output logic [2:0] row,
  output logic [2:0] line
);

  logic [10:0] hpos;
  logic [9:0]  vcnt;
  logic        odd;
  logic [9:0]  vrel;

  // ----------------------------------------
  // beam counters
  // ----------------------------------------
  // parks at all ones, outside any window
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '1;
    end else if (sol) begin
      hpos <= '0;
    end else if (hpos != '1) begin
      hpos <= hpos + 11'd1;
    end
  end

  // one osd line per two video lines
  always_ff @(posedge clk) begin
    if (reset || sof) begin
      vcnt <= '0;
      odd  <= 1'b0;
    end else if (sol) begin
      odd <= ~odd;
      if (odd && vcnt != '1) begin
        vcnt <= vcnt + 10'd1;
      end
    end
  end

  // ----------------------------------------
  // window
  // ----------------------------------------
  assign vrel = vcnt - 10'(v_start);

  assign in_window = (hpos >= 11'(h_start)) && (hpos < 11'(h_start + osd_cols)) &&
                     (vcnt >= 10'(v_start)) && (vcnt < 10'(v_start + osd_rows * 8));

  assign col  = 8'(hpos - 11'(h_start));
  assign row  = vrel[5:3];
  assign line = vrel[2:0];

  assert property (@(posedge clk) disable iff (reset) in_window |-> vcnt >= 10'(v_start));

endmodule

`default_nettype wire

//--- src/osd_cmd_regs.sv
// command decoder; only data byte 0 writes a register, chipset and memory apply while cpurst
`timescale 1ns/1ps
`default_nettype none

module osd_cmd_regs
  import osd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  input  logic       cmd,
  input  logic [7:0] data,
  output logic       osd_enable,
  output logic       key_disable,
  output logic       usrrst,
  output logic       cpurst,
  output logic       cpuhlt,
  output logic [4:0] chipset_config,
  output logic [3:0] cpu_config,
  output logic [6:0] memory_config,
  output logic [1:0] scanline,
  output logic [1:0] lr_filter,
  output logic [1:0] hr_filter,
  output logic [1:0] dither,
  output logic [3:0] floppy_config,
  output logic       buf_we,
  output buf_addr_t  buf_addr,
  output logic [7:0] buf_data
);

  logic [5:0] cmd_code;
  logic [2:0] byte_cnt;
  logic       wr0;
  logic       buf_row;
  osd_data_u  d;
  logic       sel_reset_ctrl;
  logic       sel_osd_ctrl;
  logic       sel_chip_cfg;
  logic       sel_cpu_cfg;
  logic       sel_memory_cfg;
  logic       sel_video_cfg;
  logic       sel_floppy_cfg;
  logic       sel_osd_buffer;
  logic [4:0] chip_stage;
  logic [6:0] mem_stage;

  assign d = data;

  // ----------------------------------------
  // command and byte counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_code <= 6'd0;
      byte_cnt <= 3'd0;
    end else if (rx && cmd) begin
      cmd_code <= data[7:2];
      byte_cnt <= 3'd0;
    end else if (rx && byte_cnt != 3'd4) begin
      byte_cnt <= byte_cnt + 3'd1;
    end
  end

  // one select per known code, others stay quiet
  always_comb begin
    sel_reset_ctrl = 1'b0;
    sel_osd_ctrl   = 1'b0;
    sel_chip_cfg   = 1'b0;
    sel_cpu_cfg    = 1'b0;
    sel_memory_cfg = 1'b0;
    sel_video_cfg  = 1'b0;
    sel_floppy_cfg = 1'b0;
    sel_osd_buffer = 1'b0;
    case (cmd_code)
      cmd_reset_ctrl: sel_reset_ctrl = 1'b1;
      cmd_osd_ctrl:   sel_osd_ctrl   = 1'b1;
      cmd_chip_cfg:   sel_chip_cfg   = 1'b1;
      cmd_cpu_cfg:    sel_cpu_cfg    = 1'b1;
      cmd_memory_cfg: sel_memory_cfg = 1'b1;
      cmd_video_cfg:  sel_video_cfg  = 1'b1;
      cmd_floppy_cfg: sel_floppy_cfg = 1'b1;
      cmd_osd_buffer: sel_osd_buffer = 1'b1;
      default: ;
    endcase
  end

  assign wr0     = rx && !cmd && (byte_cnt == 3'd0);
  assign buf_row = wr0 && sel_osd_buffer;

  // ----------------------------------------
  // configuration registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_enable     <= 1'b0;
      key_disable    <= 1'b0;
      usrrst         <= 1'b0;
      cpurst         <= 1'b1;
      cpuhlt         <= 1'b1;
      chip_stage     <= 5'd0;
      mem_stage      <= memory_cfg_reset;
      chipset_config <= 5'd0;
      memory_config  <= memory_cfg_reset;
      cpu_config     <= 4'd0;
      {dither, hr_filter, lr_filter, scanline} <= 8'd0;
      floppy_config  <= 4'd0;
    end else begin
      if (wr0 && sel_reset_ctrl) begin
        cpuhlt <= d.ctrl.cpuhlt;
        cpurst <= d.ctrl.cpurst;
        usrrst <= d.ctrl.usrrst;
      end
      // same low two bits as the reset view
      if (wr0 && sel_osd_ctrl) begin
        key_disable <= d.ctrl.cpurst;
        osd_enable  <= d.ctrl.usrrst;
      end
      if (wr0 && sel_chip_cfg) begin
        chip_stage <= data[4:0];
      end
      if (wr0 && sel_memory_cfg) begin
        mem_stage <= data[6:0];
      end
      if (wr0 && sel_cpu_cfg) begin
        cpu_config <= data[3:0];
      end
      if (wr0 && sel_video_cfg) begin
        dither    <= d.video.dither;
        hr_filter <= d.video.hr_filter;
        lr_filter <= d.video.lr_filter;
        scanline  <= d.video.scanline;
      end
      if (wr0 && sel_floppy_cfg) begin
        floppy_config <= data[3:0];
      end
      // staged values reach the chipset only while the cpu is held
      if (cpurst) begin
        chipset_config <= chip_stage;
        memory_config  <= mem_stage;
      end
    end
  end

  // ----------------------------------------
  // buffer write port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      buf_we <= 1'b0;
    end else begin
      buf_we <= rx && !cmd && sel_osd_buffer && (byte_cnt != 3'd0);
    end
  end

  // byte 0 picks the row, address steps after each write
  always_ff @(posedge clk) begin
    if (buf_row) begin
      buf_addr <= {data[2:0], 8'h00};
    end else if (buf_we) begin
      buf_addr <= buf_addr + 11'd1;
    end
    if (rx) begin
      buf_data <= data;
    end
  end

  // a write always follows a received byte
  assert property (@(posedge clk) disable iff (reset) buf_we |-> $past(rx));

endmodule

`default_nettype wire

//--- src/osd_spi_slave.sv
// spi mode 0 slave, msb first; sck half-period and scs_n setup must each be at least 4 clk
`timescale 1ns/1ps
`default_nettype none

module osd_spi_slave (
  input  logic       clk,
  input  logic       reset,
  input  logic       scs_n,
  input  logic       sck,
  input  logic       sdi,
  input  logic [7:0] osd_ctrl,
  output logic       sdo,
  output logic       rx,
  output logic       cmd,
  output logic [7:0] data
);

  // two sync stages, sck gets a third for edge detect
  logic [1:0] scs_q;
  logic [2:0] sck_q;
  logic [2:0] sdi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       active;
  logic [2:0] bit_cnt;
  logic       first;
  logic [6:0] rx_sr;
  logic [7:0] tx_sr;

  // ----------------------------------------
  // pin synchronizers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      scs_q <= 2'b11;
      sck_q <= 3'b000;
    end else begin
      scs_q <= {scs_q[0], scs_n};
      sck_q <= {sck_q[1:0], sck};
    end
  end

  // sdi delayed to line up with the registered edge flags
  always_ff @(posedge clk) begin
    sdi_q <= {sdi_q[1:0], sdi};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_rise <= sck_q[1] & ~sck_q[2];
      sck_fall <= ~sck_q[1] & sck_q[2];
    end
  end

  assign active = ~scs_q[1];

  // ----------------------------------------
  // receive side
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt <= 3'd0;
      first   <= 1'b1;
      rx      <= 1'b0;
      cmd     <= 1'b0;
    end else begin
      rx <= 1'b0;
      if (!active) begin
        // idle, next byte is a command
        bit_cnt <= 3'd0;
        first   <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          rx    <= 1'b1;
          cmd   <= first;
          first <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && sck_rise) begin
      rx_sr <= {rx_sr[5:0], sdi_q[2]};
      if (bit_cnt == 3'd7) begin
        data <= {rx_sr, sdi_q[2]};
      end
    end
  end

  // ----------------------------------------
  // transmit side, key code
  // ----------------------------------------
  // reload at byte end; the fall right after it is skipped so bit 7 stays up
  always_ff @(posedge clk) begin
    if (!active) begin
      tx_sr <= osd_ctrl;
    end else if (sck_rise && bit_cnt == 3'd7) begin
      tx_sr <= osd_ctrl;
    end else if (sck_fall && bit_cnt != 3'd0) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign sdo = tx_sr[7];

  // byte strobes are always separated by the sck rate
  assert property (@(posedge clk) disable iff (reset) rx |=> !rx);

endmodule

`default_nettype wire

//--- src/osd_pkg.sv
// shared osd definitions; buffer geometry is fixed at 8 rows of 256 columns, one byte per column
`default_nettype none

package osd_pkg;

  // ----------------------------------------
  // command codes, upper six bits of a command byte
  // ----------------------------------------
  localparam logic [5:0] cmd_reset_ctrl = 6'b0_000_10;
  localparam logic [5:0] cmd_osd_ctrl   = 6'b0_010_10;
  localparam logic [5:0] cmd_chip_cfg   = 6'b0_000_01;
  localparam logic [5:0] cmd_cpu_cfg    = 6'b0_001_01;
  localparam logic [5:0] cmd_memory_cfg = 6'b0_010_01;
  localparam logic [5:0] cmd_video_cfg  = 6'b0_011_01;
  localparam logic [5:0] cmd_floppy_cfg = 6'b0_100_01;
  localparam logic [5:0] cmd_osd_buffer = 6'b0_000_11;

  // buffer geometry, each byte is 8 vertical pixels
  localparam int osd_rows = 8;
  localparam int osd_cols = 256;

  typedef logic [10:0] buf_addr_t;

  // fast, slow, chip fields of the memory setting
  localparam logic [6:0] memory_cfg_reset = 7'b0_00_01_01;

  // default window origin in clocks and osd lines
  localparam int h_start_default = 64;
  localparam int v_start_default = 4;

  // ----------------------------------------
  // data byte views
  // ----------------------------------------
  typedef struct packed {
    logic [1:0] dither;
    logic [1:0] hr_filter;
    logic [1:0] lr_filter;
    logic [1:0] scanline;
  } video_cfg_t;

  // osd control reuses the low two bits as key_disable, osd_enable
  typedef struct packed {
    logic [4:0] unused;
    logic       cpuhlt;
    logic       cpurst;
    logic       usrrst;
  } ctrl_t;

  typedef union packed {
    video_cfg_t video;
    ctrl_t      ctrl;
  } osd_data_u;

endpackage

`default_nettype wire
